//--- logic/pad_params.svh
`ifndef PAD_PARAMS_SVH
`define PAD_PARAMS_SVH

// Pad ring size
`define PAD_NUM_PAD 8

// OBI bus widths
`define PAD_DATA_W 32
`define PAD_ADDR_W 32
`define PAD_BE_W   4

// Depth of the pad input synchronizer
`define PAD_SYNC_STAGES 2

// Register map, byte offsets
`define PAD_OFS_GPIO_OUT 32'h0000_0000
`define PAD_OFS_GPIO_OE  32'h0000_0004
`define PAD_OFS_GPIO_IN  32'h0000_0008
`define PAD_OFS_PAD_MUX  32'h0000_000C
`define PAD_OFS_EXIT     32'h0000_0010

`endif

//--- logic/pad_pkg.sv
`include "pad_params.svh"

package pad_pkg;

  // --------------------------------------------------
  // OBI bus
  // --------------------------------------------------
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`PAD_BE_W-1:0]   be;
    logic [`PAD_ADDR_W-1:0] addr;
    logic [`PAD_DATA_W-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic                   gnt;
    logic                   rvalid;
    logic [`PAD_DATA_W-1:0] rdata;
  } obi_rsp_t;

  // --------------------------------------------------
  // Register access
  // --------------------------------------------------
  typedef enum logic [2:0] {
    NONE     = 3'd0,
    GPIO_OUT = 3'd1,
    GPIO_OE  = 3'd2,
    GPIO_IN  = 3'd3,
    PAD_MUX  = 3'd4,
    EXIT     = 3'd5
  } reg_sel_e;

  // One access per granted request
  typedef struct packed {
    logic                   valid;
    logic                   we;
    reg_sel_e               sel;
    logic [`PAD_BE_W-1:0]   be;
    logic [`PAD_DATA_W-1:0] wdata;
  } reg_access_t;

  // Per-pad function select
  typedef enum logic {
    PAD_FN_GPIO = 1'b0,
    PAD_FN_ALT  = 1'b1
  } pad_fn_e;

endpackage

//--- logic/obi_reg_ctrl.sv
`timescale 1ns/10ps
`include "pad_params.svh"

module obi_reg_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  pad_pkg::obi_req_t      obi_req_i,
  output pad_pkg::obi_rsp_t      obi_rsp_o,
  output pad_pkg::reg_access_t   access_o,
  input  logic [`PAD_DATA_W-1:0] gpio_rdata_i,
  input  logic [`PAD_DATA_W-1:0] pad_rdata_i
);
  import pad_pkg::*;

  logic [`PAD_ADDR_W-1:0] word_addr;
  reg_sel_e               sel;
  logic [`PAD_DATA_W-1:0] rd_mux;
  logic                   rvalid_q;
  logic [`PAD_DATA_W-1:0] rdata_q;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  // Byte offset inside the word is ignored
  assign word_addr = {obi_req_i.addr[`PAD_ADDR_W-1:2], 2'b00};

  always_comb begin
    case (word_addr)
      `PAD_OFS_GPIO_OUT: sel = GPIO_OUT;
      `PAD_OFS_GPIO_OE:  sel = GPIO_OE;
      `PAD_OFS_GPIO_IN:  sel = GPIO_IN;
      `PAD_OFS_PAD_MUX:  sel = PAD_MUX;
      `PAD_OFS_EXIT:     sel = EXIT;
      default:           sel = NONE;
    endcase
  end

  // No back-pressure, so every request is an accepted access
  always_comb begin
    access_o.valid = obi_req_i.req;
    access_o.we    = obi_req_i.we;
    access_o.sel   = sel;
    access_o.be    = obi_req_i.be;
    access_o.wdata = obi_req_i.wdata;
  end

  // Read data from the block owning the selected register
  always_comb begin
    case (sel)
      GPIO_OUT, GPIO_OE, GPIO_IN: rd_mux = gpio_rdata_i;
      PAD_MUX, EXIT:              rd_mux = pad_rdata_i;
      default:                    rd_mux = '0;
    endcase
  end

  // --------------------------------------------------
  // Response
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
    end
  end

  // Old register contents are sampled, writes answer zero
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= obi_req_i.we ? '0 : rd_mux;
    end
  end

  always_comb begin
    obi_rsp_o.gnt    = obi_req_i.req;
    obi_rsp_o.rvalid = rvalid_q;
    obi_rsp_o.rdata  = rdata_q;
  end

endmodule

//--- logic/gpio_regs.sv
`timescale 1ns/10ps
`include "pad_params.svh"

module gpio_regs (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  pad_pkg::reg_access_t    access_i,
  input  logic [`PAD_NUM_PAD-1:0] pad_in_i,
  output logic [`PAD_NUM_PAD-1:0] gpio_out_o,
  output logic [`PAD_NUM_PAD-1:0] gpio_oe_o,
  output logic [`PAD_DATA_W-1:0]  rdata_o
);
  import pad_pkg::*;

  logic [`PAD_NUM_PAD-1:0]                      gpio_out_q;
  logic [`PAD_NUM_PAD-1:0]                      gpio_oe_q;
  logic [`PAD_SYNC_STAGES-1:0][`PAD_NUM_PAD-1:0] sync_q;
  logic                                         wr_en;

  // Lane-masked update, pad k sits in byte lane k/8
  function automatic logic [`PAD_NUM_PAD-1:0] merge_be(
    input logic [`PAD_NUM_PAD-1:0] old_val,
    input logic [`PAD_DATA_W-1:0]  wdata,
    input logic [`PAD_BE_W-1:0]    be
  );
    logic [`PAD_NUM_PAD-1:0] res;
    res = old_val;
    for (int i = 0; i < `PAD_NUM_PAD; i++) begin
      if (be[i/8]) res[i] = wdata[i];
    end
    return res;
  endfunction

  assign wr_en = access_i.valid && access_i.we;

  // --------------------------------------------------
  // Output and output-enable registers
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
    end else if (wr_en) begin
      if (access_i.sel == GPIO_OUT) begin
        gpio_out_q <= merge_be(gpio_out_q, access_i.wdata, access_i.be);
      end
      if (access_i.sel == GPIO_OE) begin
        gpio_oe_q <= merge_be(gpio_oe_q, access_i.wdata, access_i.be);
      end
    end
  end

  // Input synchronizer, last stage feeds GPIO_IN
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[`PAD_SYNC_STAGES-2:0], pad_in_i};
    end
  end

  assign gpio_out_o = gpio_out_q;
  assign gpio_oe_o  = gpio_oe_q;

  always_comb begin
    case (access_i.sel)
      GPIO_OUT: rdata_o = `PAD_DATA_W'(gpio_out_q);
      GPIO_OE:  rdata_o = `PAD_DATA_W'(gpio_oe_q);
      GPIO_IN:  rdata_o = `PAD_DATA_W'(sync_q[`PAD_SYNC_STAGES-1]);
      default:  rdata_o = '0;
    endcase
  end

endmodule

//--- logic/pad_ctrl_regs.sv
`timescale 1ns/10ps
`include "pad_params.svh"

module pad_ctrl_regs (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  pad_pkg::reg_access_t    access_i,
  output logic [`PAD_NUM_PAD-1:0] pad_mux_o,
  output logic [`PAD_DATA_W-1:0]  exit_value_o,
  output logic                    exit_valid_o,
  output logic [`PAD_DATA_W-1:0]  rdata_o
);
  import pad_pkg::*;

  logic [`PAD_NUM_PAD-1:0] pad_mux_q;
  logic [`PAD_DATA_W-1:0]  exit_value_q;
  logic                    exit_valid_q;
  logic                    wr_mux;
  logic                    wr_exit;

  assign wr_mux  = access_i.valid && access_i.we && (access_i.sel == PAD_MUX);
  assign wr_exit = access_i.valid && access_i.we && (access_i.sel == EXIT);

  // --------------------------------------------------
  // Pad-mux select register
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pad_mux_q <= '0;
    end else if (wr_mux) begin
      for (int i = 0; i < `PAD_NUM_PAD; i++) begin
        if (access_i.be[i/8]) pad_mux_q[i] <= access_i.wdata[i];
      end
    end
  end

  // --------------------------------------------------
  // Exit value and valid
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_value_q <= '0;
    end else if (wr_exit) begin
      for (int b = 0; b < `PAD_BE_W; b++) begin
        if (access_i.be[b]) exit_value_q[8*b +: 8] <= access_i.wdata[8*b +: 8];
      end
    end
  end

  // Sticky once set, even for an all-zero byte enable
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
    end else if (wr_exit) begin
      exit_valid_q <= 1'b1;
    end
  end

  assign pad_mux_o    = pad_mux_q;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

  always_comb begin
    case (access_i.sel)
      PAD_MUX: rdata_o = `PAD_DATA_W'(pad_mux_q);
      EXIT:    rdata_o = exit_value_q;
      default: rdata_o = '0;
    endcase
  end

endmodule

//--- logic/pad_mux.sv
`timescale 1ns/10ps
`include "pad_params.svh"

module pad_mux (
  input  logic [`PAD_NUM_PAD-1:0] pad_mux_i,
  input  logic [`PAD_NUM_PAD-1:0] gpio_out_i,
  input  logic [`PAD_NUM_PAD-1:0] gpio_oe_i,
  input  logic [`PAD_NUM_PAD-1:0] exit_bits_i,
  input  logic [`PAD_NUM_PAD-1:0] pad_i,
  output logic [`PAD_NUM_PAD-1:0] pad_o,
  output logic [`PAD_NUM_PAD-1:0] pad_oe_o,
  output logic [`PAD_NUM_PAD-1:0] gpio_in_o
);
  import pad_pkg::*;

  // Shared pads, one select bit per pad
  always_comb begin
    for (int k = 0; k < `PAD_NUM_PAD; k++) begin
      case (pad_fn_e'(pad_mux_i[k]))
        PAD_FN_ALT: begin
          // Exit bit always drives the pad
          pad_o[k]     = exit_bits_i[k];
          pad_oe_o[k]  = 1'b1;
          gpio_in_o[k] = 1'b0;
        end
        default: begin
          pad_o[k]     = gpio_out_i[k];
          pad_oe_o[k]  = gpio_oe_i[k];
          gpio_in_o[k] = pad_i[k];
        end
      endcase
    end
  end

endmodule

//--- logic/heep_pad_top.sv
`timescale 1ns/10ps
`include "pad_params.svh"

module heep_pad_top (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // External OBI master
  input  pad_pkg::obi_req_t       obi_req_i,
  output pad_pkg::obi_rsp_t       obi_rsp_o,

  // Pads
  input  logic [`PAD_NUM_PAD-1:0] pad_i,
  output logic [`PAD_NUM_PAD-1:0] pad_o,
  output logic [`PAD_NUM_PAD-1:0] pad_oe_o,

  // Exit status
  output logic                    exit_valid_o,
  output logic [`PAD_DATA_W-1:0]  exit_value_o
);
  import pad_pkg::*;

  // --------------------------------------------------
  // Internal signals
  // --------------------------------------------------
  reg_access_t             access;
  logic [`PAD_DATA_W-1:0]  gpio_rdata;
  logic [`PAD_DATA_W-1:0]  pad_rdata;
  logic [`PAD_NUM_PAD-1:0] gpio_out;
  logic [`PAD_NUM_PAD-1:0] gpio_oe;
  logic [`PAD_NUM_PAD-1:0] gpio_in;
  logic [`PAD_NUM_PAD-1:0] pad_mux_sel;

  // Bus slave and register decode
  obi_reg_ctrl u_obi_reg_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .obi_req_i   (obi_req_i),
    .obi_rsp_o   (obi_rsp_o),
    .access_o    (access),
    .gpio_rdata_i(gpio_rdata),
    .pad_rdata_i (pad_rdata)
  );

  gpio_regs u_gpio_regs (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .access_i  (access),
    .pad_in_i  (gpio_in),
    .gpio_out_o(gpio_out),
    .gpio_oe_o (gpio_oe),
    .rdata_o   (gpio_rdata)
  );

  pad_ctrl_regs u_pad_ctrl_regs (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .access_i    (access),
    .pad_mux_o   (pad_mux_sel),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o),
    .rdata_o     (pad_rdata)
  );

  // Low exit bits form the alternate function
  pad_mux u_pad_mux (
    .pad_mux_i  (pad_mux_sel),
    .gpio_out_i (gpio_out),
    .gpio_oe_i  (gpio_oe),
    .exit_bits_i(exit_value_o[`PAD_NUM_PAD-1:0]),
    .pad_i      (pad_i),
    .pad_o      (pad_o),
    .pad_oe_o   (pad_oe_o),
    .gpio_in_o  (gpio_in)
  );

endmodule

//--- test/heep_pad_checker.sv
`timescale 1ns/10ps

module heep_pad_checker (
  input logic              clk_i,
  input logic              rst_i,
  input pad_pkg::obi_req_t obi_req_i,
  input pad_pkg::obi_rsp_t obi_rsp_i,
  input logic              exit_valid_i
);

  // Failure counts per property
  int gnt_fails = 0;
  int resp_fails = 0;
  int spurious_fails = 0;
  int exit_fails = 0;
  int fail_cnt;

  assign fail_cnt = gnt_fails + resp_fails + spurious_fails + exit_fails;

  // --------------------------------------------------
  // OBI handshake
  // --------------------------------------------------
  gnt_follows_req: assert property (
    @(posedge clk_i) disable iff (rst_i) obi_rsp_i.gnt == obi_req_i.req
  ) else begin
    gnt_fails++;
    $error("gnt differs from req");
  end

  // One response exactly one cycle after each accepted request
  rvalid_after_accept: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (obi_req_i.req && obi_rsp_i.gnt) |=> obi_rsp_i.rvalid
  ) else begin
    resp_fails++;
    $error("rvalid missing one cycle after an accepted request");
  end

  no_spurious_rvalid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    obi_rsp_i.rvalid |-> $past(obi_req_i.req && obi_rsp_i.gnt)
  ) else begin
    spurious_fails++;
    $error("rvalid without a preceding accepted request");
  end

  // --------------------------------------------------
  // Exit status
  // --------------------------------------------------
  exit_valid_sticky: assert property (
    @(posedge clk_i) disable iff (rst_i) exit_valid_i |=> exit_valid_i
  ) else begin
    exit_fails++;
    $error("exit_valid fell outside reset");
  end

endmodule

bind heep_pad_top heep_pad_checker u_checker (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .obi_req_i   (obi_req_i),
  .obi_rsp_i   (obi_rsp_o),
  .exit_valid_i(exit_valid_o)
);

//--- test/heep_pad_tb.sv
`timescale 1ns/10ps
`include "pad_params.svh"

module heep_pad_tb;
  import pad_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_WAIT = 8;
  // Cycle budgets of reset and tests 1 to 6
  localparam int TEST_CYCLES = 16 + 30 + 120 + 80 + 80 + 40 + 30;
  localparam logic [31:0] RW_ADDR [4] = '{`PAD_OFS_GPIO_OUT, `PAD_OFS_GPIO_OE,
                                          `PAD_OFS_PAD_MUX, `PAD_OFS_EXIT};

  logic                    clk;
  logic                    rst;
  obi_req_t                obi_req;
  obi_rsp_t                obi_rsp;
  logic [`PAD_NUM_PAD-1:0] pad_i;
  logic [`PAD_NUM_PAD-1:0] pad_o;
  logic [`PAD_NUM_PAD-1:0] pad_oe;
  logic                    exit_valid;
  logic [`PAD_DATA_W-1:0]  exit_value;

  int          seed = 69;
  int          errors = 0;
  int          test_num = 0;
  int          tests_failed = 0;
  int          fails_before = 0;
  int          idx;
  logic [31:0] rnd;

  // Reference model of the register map
  logic [`PAD_NUM_PAD-1:0] m_out = '0;
  logic [`PAD_NUM_PAD-1:0] m_oe = '0;
  logic [`PAD_NUM_PAD-1:0] m_mux = '0;
  logic [`PAD_NUM_PAD-1:0] pad_val = '0;
  logic [31:0]             m_exit = '0;
  logic                    m_exit_valid = 1'b0;

  heep_pad_top uut (
    .clk_i       (clk),
    .rst_i       (rst),
    .obi_req_i   (obi_req),
    .obi_rsp_o   (obi_rsp),
    .pad_i       (pad_i),
    .pad_o       (pad_o),
    .pad_oe_o    (pad_oe),
    .exit_valid_o(exit_valid),
    .exit_value_o(exit_value)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not complete", 2 * TEST_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Model and checks
  // --------------------------------------------------
  function automatic int total_errors();
    return errors + uut.u_checker.fail_cnt;
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic [31:0] res;
    case (addr)
      `PAD_OFS_GPIO_OUT: res = 32'(m_out);
      `PAD_OFS_GPIO_OE:  res = 32'(m_oe);
      // Pads on the alternate function read as zero
      `PAD_OFS_GPIO_IN:  res = 32'(pad_val & ~m_mux);
      `PAD_OFS_PAD_MUX:  res = 32'(m_mux);
      `PAD_OFS_EXIT:     res = m_exit;
      default:           res = 32'h0;
    endcase
    return res;
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [3:0] be,
                                      input logic [31:0] wdata);
    logic [31:0] v;
    v = model_read(addr);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        v[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    case (addr)
      `PAD_OFS_GPIO_OUT: m_out = v[`PAD_NUM_PAD-1:0];
      `PAD_OFS_GPIO_OE:  m_oe = v[`PAD_NUM_PAD-1:0];
      `PAD_OFS_PAD_MUX:  m_mux = v[`PAD_NUM_PAD-1:0];
      `PAD_OFS_EXIT: begin
        m_exit = v;
        m_exit_valid = 1'b1;
      end
      default: ;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
    else begin
      $display("ERR %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    int n;
    n = total_errors() - fails_before;
    test_num++;
    if (n != 0) begin
      tests_failed++;
    end
    $display("test %0d %s: %s (%0d errors)", test_num, name, (n == 0) ? "ok" : "failed", n);
    fails_before = total_errors();
  endtask

  // --------------------------------------------------
  // Bus and pad stimulus
  // --------------------------------------------------
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    obi_req_t pkt;
    int       waited;
    pkt = '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    waited = 0;
    @(posedge clk);
    obi_req <= pkt;
    do begin
      @(negedge clk);
      waited++;
    end while (!obi_rsp.gnt && waited < MAX_WAIT);
    // Accepting edge
    @(posedge clk);
    obi_req.req <= 1'b0;
    do begin
      @(negedge clk);
      waited++;
    end while (!obi_rsp.rvalid && waited < MAX_WAIT);
    if (!obi_rsp.rvalid) begin
      $display("no response from the DUT within %0d cycles at address %h", MAX_WAIT, addr);
      errors++;
    end
    rdata = obi_rsp.rdata;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] wr_rdata;
    bus_access(1'b1, addr, be, wdata, wr_rdata);
    check_value("obi_rsp.rdata on write", 32'h0, wr_rdata);
    model_write(addr, be, wdata);
  endtask

  task automatic read_check(input logic [31:0] addr);
    logic [31:0] rdata;
    bus_access(1'b0, addr, 4'hF, 32'h0, rdata);
    check_value($sformatf("obi_rsp.rdata at %h", addr), model_read(addr), rdata);
  endtask

  task automatic read_all();
    // Let the input synchronizer settle
    repeat (3) @(posedge clk);
    for (int i = 0; i < 5; i++) begin
      read_check(32'(4 * i));
    end
  endtask

  // Sampled in the cycle right after the last writing edge
  task automatic check_pads();
    check_value("pad_o", 32'((m_mux & m_exit[`PAD_NUM_PAD-1:0]) | (~m_mux & m_out)),
                32'(pad_o));
    check_value("pad_oe_o", 32'(m_mux | m_oe), 32'(pad_oe));
    check_value("exit_value_o", m_exit, exit_value);
    check_value("exit_valid_o", 32'(m_exit_valid), 32'(exit_valid));
  endtask

  task automatic drive_pads(input logic [`PAD_NUM_PAD-1:0] val);
    @(posedge clk);
    pad_i <= val;
    pad_val = val;
    // Two synchronizer stages and a spare cycle
    repeat (3) @(posedge clk);
  endtask

  // Requests in every cycle with responses checked in order
  task automatic back_to_back(input int n);
    logic [31:0] exp_q[$];
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic        we;
    int          waited;
    fork
      begin
        for (int i = 0; i < n; i++) begin
          rnd = $random(seed);
          addr = RW_ADDR[rnd[1:0]];
          we = rnd[2];
          be = rnd[7:4];
          wdata = $random(seed);
          @(posedge clk);
          obi_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
          exp_q.push_back(we ? 32'h0 : model_read(addr));
          if (we) begin
            model_write(addr, be, wdata);
          end
        end
        @(posedge clk);
        obi_req.req <= 1'b0;
      end
      begin
        waited = 0;
        do begin
          @(negedge clk);
          waited++;
        end while (!obi_rsp.rvalid && waited < MAX_WAIT);
        for (int i = 0; i < n; i++) begin
          if (i > 0) begin
            @(negedge clk);
          end
          check_value("obi_rsp.rvalid", 32'h1, 32'(obi_rsp.rvalid));
          check_value($sformatf("obi_rsp.rdata of access %0d", i), exp_q.pop_front(),
                      obi_rsp.rdata);
        end
      end
    join
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    rst <= 1'b1;
    obi_req <= '0;
    pad_i <= '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    read_all();
    check_pads();
    end_test("reset values");

    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      idx = rnd[5:4] % 3;
      write_reg(RW_ADDR[idx], rnd[3:0], $random(seed));
      read_check(RW_ADDR[idx]);
    end
    // Read-only and unmapped targets
    write_reg(`PAD_OFS_GPIO_IN, 4'hF, 32'hFFFF_FFFF);
    write_reg(32'h0000_0014, 4'hF, $random(seed));
    write_reg(32'h0000_0100, 4'hF, $random(seed));
    read_all();
    read_check(32'h0000_0014);
    read_check(32'h0000_0100);
    end_test("masked and ignored writes");

    for (int t = 0; t < 2; t++) begin
      for (int i = 0; i < 4; i++) begin
        rnd = $random(seed);
        write_reg(`PAD_OFS_PAD_MUX, 4'hF, (t == 0) ? 32'h0 : rnd);
        write_reg(`PAD_OFS_GPIO_OUT, 4'hF, $random(seed));
        write_reg(`PAD_OFS_GPIO_OE, 4'hF, $random(seed));
        rnd = $random(seed);
        drive_pads(rnd[`PAD_NUM_PAD-1:0]);
        read_check(`PAD_OFS_GPIO_IN);
        check_pads();
      end
      if (t == 0) begin
        end_test("gpio pads");
      end else begin
        end_test("pad mux selects");
      end
    end

    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      write_reg(`PAD_OFS_EXIT, (i == 0) ? 4'hF : rnd[3:0], $random(seed));
      check_pads();
      read_check(`PAD_OFS_EXIT);
    end
    end_test("exit value and valid");

    back_to_back(12);
    end_test("back-to-back accesses");

    $display("tests run: %0d, tests failed: %0d, errors: %0d",
             test_num, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+logic
logic/pad_pkg.sv
logic/obi_reg_ctrl.sv
logic/gpio_regs.sv
logic/pad_ctrl_regs.sv
logic/pad_mux.sv
logic/heep_pad_top.sv
test/heep_pad_checker.sv
test/heep_pad_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = heep_pad_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+100
SOURCES   = $(wildcard logic/*.sv logic/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass message appears in the output
run: $(SIM)
	@out="$$(./$(SIM) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
